// File: include/csr_params.svh
/* CSR widths, addresses, field positions and cause codes for a 32-bit M/U-mode core.
   Interrupt bit positions in mie/mip double as the interrupt cause codes. */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN 32

// Machine-mode CSR addresses
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MISA     12'h301
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVAL    12'h343
`define CSR_ADDR_MIP      12'h344

// mstatus fields, MPP occupies two bits
`define CSR_BIT_MIE  3
`define CSR_BIT_MPIE 7
`define CSR_BIT_MPP  11

// mie/mip positions and interrupt codes
`define CSR_BIT_MSI 3
`define CSR_BIT_MTI 7
`define CSR_BIT_MEI 11

// Exception codes
`define CSR_CAUSE_ILLEGAL 2
`define CSR_CAUSE_ECALL_U 8
`define CSR_CAUSE_ECALL_M 11

// MXL = 1 (32 bit), extensions I and U
`define CSR_MISA_VALUE 32'h4010_0100

`endif

// File: logic/csr_pkg.sv
/* Shared types for the CSR file. Only M and U privilege levels exist,
   so the privilege enum has no encoding for S. */
`include "csr_params.svh"

package csr_pkg;

  // One data word
  typedef logic [`CSR_XLEN-1:0] xlen_t;

  // CSR address as carried in the instruction
  typedef logic [11:0] csr_addr_t;

  // Memory-mapped timer values
  typedef logic [63:0] time_t;

  // Raw instruction word, stored into mtval on an illegal instruction
  typedef logic [31:0] instr_t;

  // Privilege level, encodings follow the privileged spec
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_t;

endpackage

// File: logic/status_priv.sv
/* mstatus (MIE, MPIE, MPP) and the current privilege level.
   Update priority is trap, then mret, then a software write. */
`include "csr_params.svh"

module status_priv (
  input  logic               clock,
  input  logic               reset,
  input  logic               wr_en,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     wr_data,
  input  logic               trap,
  input  logic               mret,
  output csr_pkg::xlen_t     mstatus,
  output csr_pkg::priv_t     priv
);
  import csr_pkg::*;

  logic       mie_q;
  logic       mpie_q;
  priv_t      mpp_q;
  logic       status_wr;
  logic [1:0] wr_mpp;
  logic       wr_mpp_legal;

  assign status_wr = wr_en && (addr == `CSR_ADDR_MSTATUS);
  assign wr_mpp    = wr_data[`CSR_BIT_MPP+1:`CSR_BIT_MPP];

  // MPP is WARL, only U and M are kept
  assign wr_mpp_legal = (wr_mpp == PRIV_U) || (wr_mpp == PRIV_M);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
      mpp_q  <= PRIV_U;
      priv   <= PRIV_M;
    end else if (trap) begin
      // Stack the interrupt enable and enter M mode
      mie_q  <= 1'b0;
      mpie_q <= mie_q;
      mpp_q  <= priv;
      priv   <= PRIV_M;
    end else if (mret) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
      mpp_q  <= PRIV_U;
      priv   <= mpp_q;
    end else if (status_wr) begin
      mie_q  <= wr_data[`CSR_BIT_MIE];
      mpie_q <= wr_data[`CSR_BIT_MPIE];
      if (wr_mpp_legal) begin
        mpp_q <= priv_t'(wr_mpp);
      end
    end
  end

  // Visible fields, everything else reads zero
  always_comb begin
    mstatus = '0;
    mstatus[`CSR_BIT_MIE] = mie_q;
    mstatus[`CSR_BIT_MPIE] = mpie_q;
    mstatus[`CSR_BIT_MPP+1:`CSR_BIT_MPP] = mpp_q;
  end

endmodule

// File: logic/machine_setup_regs.sv
/* mtvec, mie and mscratch, plus the read-only mip view.
   mip bits come straight from the external, software and timer lines and cannot be written. */
`include "csr_params.svh"

module machine_setup_regs (
  input  logic               clock,
  input  logic               reset,
  input  logic               wr_en,
  input  logic               trap,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     wr_data,
  input  logic               external_interrupt,
  input  logic               mem_msip,
  input  csr_pkg::time_t     mem_mtime,
  input  csr_pkg::time_t     mem_mtimecmp,
  output csr_pkg::xlen_t     mtvec,
  output csr_pkg::xlen_t     mie_bits,
  output csr_pkg::xlen_t     mip_bits,
  output csr_pkg::xlen_t     mscratch
);

  logic msie_q;
  logic mtie_q;
  logic meie_q;
  logic setup_wr;
  logic timer_due;

  // A trap in the same cycle cancels the write
  assign setup_wr  = wr_en && !trap;
  assign timer_due = mem_mtime >= mem_mtimecmp;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec    <= '0;
      msie_q   <= 1'b0;
      mtie_q   <= 1'b0;
      meie_q   <= 1'b0;
      mscratch <= '0;
    end else if (setup_wr) begin
      case (addr)
        // Bit 1 is reserved and stays zero
        `CSR_ADDR_MTVEC: mtvec <= {wr_data[`CSR_XLEN-1:2], 1'b0, wr_data[0]};
        `CSR_ADDR_MIE: begin
          msie_q <= wr_data[`CSR_BIT_MSI];
          mtie_q <= wr_data[`CSR_BIT_MTI];
          meie_q <= wr_data[`CSR_BIT_MEI];
        end
        `CSR_ADDR_MSCRATCH: mscratch <= wr_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    mie_bits = '0;
    mie_bits[`CSR_BIT_MSI] = msie_q;
    mie_bits[`CSR_BIT_MTI] = mtie_q;
    mie_bits[`CSR_BIT_MEI] = meie_q;
  end

  // Pending lines as seen this cycle
  always_comb begin
    mip_bits = '0;
    mip_bits[`CSR_BIT_MSI] = mem_msip;
    mip_bits[`CSR_BIT_MTI] = timer_due;
    mip_bits[`CSR_BIT_MEI] = external_interrupt;
  end

endmodule

// File: logic/trap_control.sv
/* Combinational trap decision: qualifies interrupts and exceptions, picks the
   highest priority one, and forms the cause and target address. All traps go to M mode. */
`include "csr_params.svh"

module trap_control (
  input  csr_pkg::priv_t priv,
  input  csr_pkg::xlen_t mstatus,
  input  csr_pkg::xlen_t mie_bits,
  input  csr_pkg::xlen_t mip_bits,
  input  csr_pkg::xlen_t mtvec,
  input  logic           illegal_instruction,
  input  logic           ecall,
  output logic           trap,
  output csr_pkg::xlen_t trap_cause,
  output csr_pkg::xlen_t trap_addr
);
  import csr_pkg::*;

  // Top bit of the cause marks an interrupt
  localparam xlen_t INT_FLAG = {1'b1, {(`CSR_XLEN-1){1'b0}}};

  logic  global_en;
  logic  take_mei;
  logic  take_mti;
  logic  take_msi;
  logic  take_illegal;
  logic  take_ecall;
  logic  is_interrupt;
  xlen_t ecall_cause;
  xlen_t base_addr;
  xlen_t vector_addr;

  // U mode is always interruptible, M mode only with MIE
  assign global_en = (priv == PRIV_U) || ((priv == PRIV_M) && mstatus[`CSR_BIT_MIE]);

  assign take_mei = mie_bits[`CSR_BIT_MEI] && mip_bits[`CSR_BIT_MEI] && global_en;
  assign take_mti = mie_bits[`CSR_BIT_MTI] && mip_bits[`CSR_BIT_MTI] && global_en;
  assign take_msi = mie_bits[`CSR_BIT_MSI] && mip_bits[`CSR_BIT_MSI] && global_en;

  assign take_illegal = illegal_instruction && global_en;
  assign take_ecall   = ecall && global_en;

  assign is_interrupt = take_mei || take_mti || take_msi;
  assign trap         = is_interrupt || take_illegal || take_ecall;

  // ecall code depends on where it came from
  assign ecall_cause = (priv == PRIV_U) ? xlen_t'(`CSR_CAUSE_ECALL_U)
                                        : xlen_t'(`CSR_CAUSE_ECALL_M);

  // Fixed priority, interrupts ahead of exceptions
  always_comb begin
    if (take_mei) begin
      trap_cause = INT_FLAG | xlen_t'(`CSR_BIT_MEI);
    end else if (take_mti) begin
      trap_cause = INT_FLAG | xlen_t'(`CSR_BIT_MTI);
    end else if (take_msi) begin
      trap_cause = INT_FLAG | xlen_t'(`CSR_BIT_MSI);
    end else if (take_illegal) begin
      trap_cause = xlen_t'(`CSR_CAUSE_ILLEGAL);
    end else if (take_ecall) begin
      trap_cause = ecall_cause;
    end else begin
      trap_cause = '0;
    end
  end

  assign base_addr = {mtvec[`CSR_XLEN-1:2], 2'b00};

  // Vectored entry is base + 4 * code, the add works on word addresses
  assign vector_addr = {mtvec[`CSR_XLEN-1:2] + trap_cause[`CSR_XLEN-3:0], 2'b00};

  // Vectoring applies to interrupts only
  assign trap_addr = (mtvec[0] && is_interrupt) ? vector_addr : base_addr;

endmodule

// File: logic/trap_state_regs.sv
/* mepc, mcause and mtval. A trap overrides any software write in the same cycle.
   mcause is WLRL and keeps its old value when an unsupported code is written. */
`include "csr_params.svh"

module trap_state_regs (
  input  logic               clock,
  input  logic               reset,
  input  logic               wr_en,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     wr_data,
  input  logic               trap,
  input  csr_pkg::xlen_t     trap_cause,
  input  csr_pkg::xlen_t     pc,
  input  csr_pkg::instr_t    instruction,
  input  logic               illegal_instruction,
  output csr_pkg::xlen_t     mepc,
  output csr_pkg::xlen_t     mcause,
  output csr_pkg::xlen_t     mtval
);
  import csr_pkg::*;

  logic capture_instr;

  // Codes this core can actually raise
  function automatic logic cause_legal(input xlen_t value);
    logic [`CSR_XLEN-2:0] code;
    code = value[`CSR_XLEN-2:0];
    if (value[`CSR_XLEN-1]) begin
      return (code == `CSR_BIT_MSI) || (code == `CSR_BIT_MTI) || (code == `CSR_BIT_MEI);
    end
    return (code == `CSR_CAUSE_ILLEGAL) || (code == `CSR_CAUSE_ECALL_U) ||
           (code == `CSR_CAUSE_ECALL_M);
  endfunction

  // Only an illegal-instruction trap records the instruction word
  assign capture_instr = illegal_instruction &&
                         (trap_cause == xlen_t'(`CSR_CAUSE_ILLEGAL));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap) begin
      mepc   <= pc;
      mcause <= trap_cause;
      if (capture_instr) begin
        mtval <= instruction;
      end
    end else if (wr_en) begin
      case (addr)
        `CSR_ADDR_MEPC: mepc <= {wr_data[`CSR_XLEN-1:2], 2'b00};
        `CSR_ADDR_MCAUSE: begin
          if (cause_legal(wr_data)) begin
            mcause <= wr_data;
          end
        end
        `CSR_ADDR_MTVAL: mtval <= wr_data;
        default: ;
      endcase
    end
  end

endmodule

// File: logic/csr_file.sv
/* Machine-mode CSR file. Writes land on the clock edge and are dropped while trap is high;
   reads are combinational from addr. The core must never assert mret together with wr_en. */
`include "csr_params.svh"

module csr_file (
  input  logic              clock,
  input  logic              reset,
  input  logic              wr_en,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t    wr_data,
  input  csr_pkg::xlen_t    pc,
  input  csr_pkg::instr_t   instruction,
  input  logic              illegal_instruction,
  input  logic              ecall,
  input  logic              mret,
  input  logic              external_interrupt,
  input  logic              mem_msip,
  input  csr_pkg::time_t    mem_mtime,
  input  csr_pkg::time_t    mem_mtimecmp,
  output csr_pkg::xlen_t    rd_data,
  output csr_pkg::xlen_t    mepc,
  output csr_pkg::xlen_t    trap_addr,
  output logic              trap,
  output csr_pkg::priv_t    privilege_mode
);
  import csr_pkg::*;

  xlen_t mstatus;
  xlen_t mtvec;
  xlen_t mie_bits;
  xlen_t mip_bits;
  xlen_t mscratch;
  xlen_t mcause;
  xlen_t mtval;
  xlen_t trap_cause;

  status_priv u_status_priv (
    .clock(clock), .reset(reset), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
    .trap(trap), .mret(mret), .mstatus(mstatus), .priv(privilege_mode)
  );

  machine_setup_regs u_machine_setup_regs (
    .clock(clock), .reset(reset), .wr_en(wr_en), .trap(trap), .addr(addr),
    .wr_data(wr_data), .external_interrupt(external_interrupt), .mem_msip(mem_msip),
    .mem_mtime(mem_mtime), .mem_mtimecmp(mem_mtimecmp), .mtvec(mtvec),
    .mie_bits(mie_bits), .mip_bits(mip_bits), .mscratch(mscratch)
  );

  trap_control u_trap_control (
    .priv(privilege_mode), .mstatus(mstatus), .mie_bits(mie_bits), .mip_bits(mip_bits),
    .mtvec(mtvec), .illegal_instruction(illegal_instruction), .ecall(ecall),
    .trap(trap), .trap_cause(trap_cause), .trap_addr(trap_addr)
  );

  trap_state_regs u_trap_state_regs (
    .clock(clock), .reset(reset), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
    .trap(trap), .trap_cause(trap_cause), .pc(pc), .instruction(instruction),
    .illegal_instruction(illegal_instruction), .mepc(mepc), .mcause(mcause), .mtval(mtval)
  );

  // Read mux, unknown addresses return zero
  always_comb begin
    case (addr)
      `CSR_ADDR_MSTATUS:  rd_data = mstatus;
      `CSR_ADDR_MISA:     rd_data = `CSR_MISA_VALUE;
      `CSR_ADDR_MIE:      rd_data = mie_bits;
      `CSR_ADDR_MTVEC:    rd_data = mtvec;
      `CSR_ADDR_MSCRATCH: rd_data = mscratch;
      `CSR_ADDR_MEPC:     rd_data = mepc;
      `CSR_ADDR_MCAUSE:   rd_data = mcause;
      `CSR_ADDR_MTVAL:    rd_data = mtval;
      `CSR_ADDR_MIP:      rd_data = mip_bits;
      default:            rd_data = '0;
    endcase
  end

endmodule

// File: bench/csr_file_tb.sv
/* Self-checking testbench for the CSR file. A register model follows the trap, mret and
   write rules and is compared with the DUT just before every rising edge. */
`include "csr_params.svh"

module csr_file_tb;
  import csr_pkg::*;

  localparam int CLOCK_PERIOD  = 20;
  localparam int RANDOM_CYCLES = 1500;
  // Reset, directed tests, random tests and a margin
  localparam int WATCHDOG_CYCLES = 10 + 300 + RANDOM_CYCLES + 200;
  localparam xlen_t INT_BIT = 32'h8000_0000;
  localparam xlen_t MIE_MASK = (32'd1 << `CSR_BIT_MSI) | (32'd1 << `CSR_BIT_MTI) |
                               (32'd1 << `CSR_BIT_MEI);
  localparam csr_addr_t CSR_ADDRS [10] = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MISA,
    `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC,
    `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP, 12'h7c0};

  logic      clock;
  logic      reset;
  logic      wr_en;
  logic      illegal_instruction;
  logic      ecall;
  logic      mret;
  logic      external_interrupt;
  logic      mem_msip;
  csr_addr_t addr;
  xlen_t     wr_data;
  xlen_t     pc;
  instr_t    instruction;
  time_t     mem_mtime;
  time_t     mem_mtimecmp;
  xlen_t     rd_data;
  xlen_t     mepc;
  xlen_t     trap_addr;
  logic      trap;
  priv_t     privilege_mode;

  // Register model
  priv_t m_priv;
  priv_t m_mpp;
  logic  m_mie;
  logic  m_mpie;
  xlen_t m_mtvec;
  xlen_t m_mie_reg;
  xlen_t m_mscratch;
  xlen_t m_mepc;
  xlen_t m_mcause;
  xlen_t m_mtval;

  logic  exp_trap;
  xlen_t exp_cause;
  xlen_t exp_target;
  int    error_count;
  int    check_count;
  int    test_count;
  int    errors_before;

  csr_file u_csr_file (.*);

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(CLOCK_PERIOD * WATCHDOG_CYCLES);
    $display("Watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic report_mismatch(input string name, input xlen_t expected, input xlen_t actual);
    $display("CHECK FAILED at time %0t: %s expected 0x%08h, got 0x%08h",
             $time, name, expected, actual);
    error_count = error_count + 1;
  endtask

  function automatic xlen_t pending_lines();
    xlen_t lines;
    lines = '0;
    lines[`CSR_BIT_MSI] = mem_msip;
    lines[`CSR_BIT_MTI] = (mem_mtime >= mem_mtimecmp);
    lines[`CSR_BIT_MEI] = external_interrupt;
    return lines;
  endfunction

  function automatic xlen_t expected_read(input csr_addr_t a);
    xlen_t value;
    value = '0;
    case (a)
      `CSR_ADDR_MSTATUS: begin
        value[`CSR_BIT_MIE] = m_mie;
        value[`CSR_BIT_MPIE] = m_mpie;
        value[`CSR_BIT_MPP+1:`CSR_BIT_MPP] = m_mpp;
      end
      `CSR_ADDR_MISA:     value = `CSR_MISA_VALUE;
      `CSR_ADDR_MIE:      value = m_mie_reg;
      `CSR_ADDR_MTVEC:    value = m_mtvec;
      `CSR_ADDR_MSCRATCH: value = m_mscratch;
      `CSR_ADDR_MEPC:     value = m_mepc;
      `CSR_ADDR_MCAUSE:   value = m_mcause;
      `CSR_ADDR_MTVAL:    value = m_mtval;
      `CSR_ADDR_MIP:      value = pending_lines();
      default:            value = '0;
    endcase
    return value;
  endfunction

  // Expected trap, cause and target from the model and the current inputs
  function automatic void trap_reference(output logic hit, output xlen_t cause,
                                         output xlen_t target);
    logic  enabled;
    xlen_t pending;
    xlen_t base;
    enabled = (m_priv == PRIV_U) || m_mie;
    pending = m_mie_reg & pending_lines();
    base = m_mtvec & 32'hffff_fffc;
    hit = enabled;
    cause = '0;
    if (enabled) begin
      if (pending[`CSR_BIT_MEI]) cause = INT_BIT | `CSR_BIT_MEI;
      else if (pending[`CSR_BIT_MTI]) cause = INT_BIT | `CSR_BIT_MTI;
      else if (pending[`CSR_BIT_MSI]) cause = INT_BIT | `CSR_BIT_MSI;
      else if (illegal_instruction) cause = `CSR_CAUSE_ILLEGAL;
      else if (ecall) cause = (m_priv == PRIV_U) ? `CSR_CAUSE_ECALL_U : `CSR_CAUSE_ECALL_M;
      else hit = 1'b0;
    end
    target = base;
    if (hit && cause[31] && m_mtvec[0]) target = base + {cause[29:0], 2'b00};
  endfunction

  function automatic logic mcause_writable(input xlen_t value);
    if (value[31]) begin
      return value[30:0] == `CSR_BIT_MSI || value[30:0] == `CSR_BIT_MTI ||
             value[30:0] == `CSR_BIT_MEI;
    end
    return value[30:0] == `CSR_CAUSE_ILLEGAL || value[30:0] == `CSR_CAUSE_ECALL_U ||
           value[30:0] == `CSR_CAUSE_ECALL_M;
  endfunction

  task automatic apply_write(input csr_addr_t a, input xlen_t d);
    case (a)
      `CSR_ADDR_MSTATUS: begin
        m_mie = d[`CSR_BIT_MIE];
        m_mpie = d[`CSR_BIT_MPIE];
        // Only U and M are legal MPP values
        if (d[`CSR_BIT_MPP+1] == d[`CSR_BIT_MPP]) begin
          m_mpp = priv_t'(d[`CSR_BIT_MPP+1:`CSR_BIT_MPP]);
        end
      end
      `CSR_ADDR_MTVEC:    m_mtvec = d & ~32'h2;
      `CSR_ADDR_MIE:      m_mie_reg = d & MIE_MASK;
      `CSR_ADDR_MSCRATCH: m_mscratch = d;
      `CSR_ADDR_MEPC:     m_mepc = d & ~32'h3;
      `CSR_ADDR_MCAUSE:   if (mcause_writable(d)) m_mcause = d;
      `CSR_ADDR_MTVAL:    m_mtval = d;
      default: ;
    endcase
  endtask

  // Next model state, as the DUT will show it after the coming edge
  task automatic update_model(input logic hit, input xlen_t cause);
    if (hit) begin
      m_mpie = m_mie;
      m_mie = 1'b0;
      m_mpp = m_priv;
      m_priv = PRIV_M;
      m_mepc = pc;
      m_mcause = cause;
      if (cause == `CSR_CAUSE_ILLEGAL) m_mtval = instruction;
    end else if (mret) begin
      m_mie = m_mpie;
      m_mpie = 1'b1;
      m_priv = m_mpp;
      m_mpp = PRIV_U;
    end else if (wr_en) begin
      apply_write(addr, wr_data);
    end
  endtask

  // Inputs are stable at the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      trap_reference(exp_trap, exp_cause, exp_target);
      check_count = check_count + 1;
      if (trap !== exp_trap) report_mismatch("trap", xlen_t'(exp_trap), xlen_t'(trap));
      if (trap_addr !== exp_target) report_mismatch("trap_addr", exp_target, trap_addr);
      if (rd_data !== expected_read(addr)) begin
        report_mismatch("rd_data", expected_read(addr), rd_data);
      end
      if (mepc !== m_mepc) report_mismatch("mepc", m_mepc, mepc);
      if (privilege_mode !== m_priv) begin
        report_mismatch("privilege_mode", xlen_t'(m_priv), xlen_t'(privilege_mode));
      end
      update_model(exp_trap, exp_cause);
    end
  end

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic set_idle();
    wr_en = 1'b0;
    mret = 1'b0;
    ecall = 1'b0;
    illegal_instruction = 1'b0;
  endtask

  task automatic csr_write(input csr_addr_t a, input xlen_t d);
    wr_en = 1'b1;
    addr = a;
    wr_data = d;
    next_cycle();
    wr_en = 1'b0;
  endtask

  task automatic expect_read(input csr_addr_t a, input xlen_t value, input string name);
    addr = a;
    @(negedge clock);
    if (rd_data !== value) report_mismatch(name, value, rd_data);
    next_cycle();
  endtask

  task automatic expect_cycle(input logic hit, input xlen_t target);
    @(negedge clock);
    if (trap !== hit) report_mismatch("trap", xlen_t'(hit), xlen_t'(trap));
    if (trap_addr !== target) report_mismatch("trap_addr", target, trap_addr);
    next_cycle();
  endtask

  task automatic enter_user(input xlen_t status);
    csr_write(`CSR_ADDR_MSTATUS, status);
    mret = 1'b1;
    next_cycle();
    mret = 1'b0;
  endtask

  task automatic finish_test(input string name);
    test_count = test_count + 1;
    if (error_count == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, error_count - errors_before);
    end
    errors_before = error_count;
  endtask

  task automatic reset_test();
    if (privilege_mode !== PRIV_M) report_mismatch("privilege_mode", 3, xlen_t'(privilege_mode));
    if (trap !== 1'b0) report_mismatch("trap", 0, xlen_t'(trap));
    expect_read(`CSR_ADDR_MSTATUS, 0, "mstatus");
    expect_read(`CSR_ADDR_MISA, `CSR_MISA_VALUE, "misa");
    expect_read(`CSR_ADDR_MIE, 0, "mie");
    expect_read(`CSR_ADDR_MTVEC, 0, "mtvec");
    expect_read(`CSR_ADDR_MSCRATCH, 0, "mscratch");
    expect_read(`CSR_ADDR_MEPC, 0, "mepc");
    expect_read(`CSR_ADDR_MCAUSE, 0, "mcause");
    expect_read(`CSR_ADDR_MTVAL, 0, "mtval");
    expect_read(`CSR_ADDR_MIP, 0, "mip");
    finish_test("reset");
  endtask

  task automatic write_test();
    csr_write(`CSR_ADDR_MSCRATCH, 32'hdead_beef);
    expect_read(`CSR_ADDR_MSCRATCH, 32'hdead_beef, "mscratch");
    csr_write(`CSR_ADDR_MTVEC, 32'h1234_5677);
    expect_read(`CSR_ADDR_MTVEC, 32'h1234_5675, "mtvec");
    csr_write(`CSR_ADDR_MIE, 32'hffff_ffff);
    expect_read(`CSR_ADDR_MIE, 32'h0000_0888, "mie");
    csr_write(`CSR_ADDR_MIE, 0);
    csr_write(`CSR_ADDR_MTVAL, 32'hcafe_f00d);
    expect_read(`CSR_ADDR_MTVAL, 32'hcafe_f00d, "mtval");
    csr_write(`CSR_ADDR_MEPC, 32'h8000_0103);
    expect_read(`CSR_ADDR_MEPC, 32'h8000_0100, "mepc");
    csr_write(`CSR_ADDR_MCAUSE, 32'h8000_0007);
    csr_write(`CSR_ADDR_MCAUSE, 32'h0000_0005);
    expect_read(`CSR_ADDR_MCAUSE, 32'h8000_0007, "mcause");
    csr_write(`CSR_ADDR_MCAUSE, 32'h0000_0008);
    csr_write(`CSR_ADDR_MCAUSE, 32'h8000_0002);
    expect_read(`CSR_ADDR_MCAUSE, 32'h0000_0008, "mcause");
    // MPP keeps M when 1 or 2 is written
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_1800);
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0800);
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_1000);
    expect_read(`CSR_ADDR_MSTATUS, 32'h0000_1800, "mstatus");
    csr_write(`CSR_ADDR_MSTATUS, 0);
    csr_write(`CSR_ADDR_MISA, 0);
    expect_read(`CSR_ADDR_MISA, `CSR_MISA_VALUE, "misa");
    csr_write(`CSR_ADDR_MIP, 32'hffff_ffff);
    expect_read(`CSR_ADDR_MIP, 0, "mip");
    finish_test("writes");
  endtask

  task automatic exception_test();
    csr_write(`CSR_ADDR_MTVEC, 32'h0000_1000);
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0008);
    pc = 32'h0000_0200;
    ecall = 1'b1;
    expect_cycle(1'b1, 32'h0000_1000);
    ecall = 1'b0;
    expect_read(`CSR_ADDR_MCAUSE, `CSR_CAUSE_ECALL_M, "mcause");
    expect_read(`CSR_ADDR_MEPC, 32'h0000_0200, "mepc");
    expect_read(`CSR_ADDR_MSTATUS, 32'h0000_1880, "mstatus");
    enter_user(32'h0000_0080);
    if (privilege_mode !== PRIV_U) report_mismatch("privilege_mode", 0, xlen_t'(privilege_mode));
    expect_read(`CSR_ADDR_MSTATUS, 32'h0000_0088, "mstatus");
    pc = 32'h0000_0404;
    ecall = 1'b1;
    expect_cycle(1'b1, 32'h0000_1000);
    ecall = 1'b0;
    expect_read(`CSR_ADDR_MCAUSE, `CSR_CAUSE_ECALL_U, "mcause");
    expect_read(`CSR_ADDR_MEPC, 32'h0000_0404, "mepc");
    expect_read(`CSR_ADDR_MSTATUS, 32'h0000_0080, "mstatus");
    enter_user(32'h0000_0080);
    pc = 32'h0000_0500;
    instruction = 32'h8c00_2073;
    illegal_instruction = 1'b1;
    expect_cycle(1'b1, 32'h0000_1000);
    illegal_instruction = 1'b0;
    expect_read(`CSR_ADDR_MTVAL, 32'h8c00_2073, "mtval");
    expect_read(`CSR_ADDR_MCAUSE, `CSR_CAUSE_ILLEGAL, "mcause");
    finish_test("exceptions");
  endtask

  task automatic interrupt_test();
    csr_write(`CSR_ADDR_MIE, MIE_MASK);
    external_interrupt = 1'b1;
    // M mode with MIE clear ignores the line
    expect_cycle(1'b0, 32'h0000_1000);
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0008);
    expect_cycle(1'b1, 32'h0000_1000);
    expect_read(`CSR_ADDR_MCAUSE, INT_BIT | `CSR_BIT_MEI, "mcause");
    csr_write(`CSR_ADDR_MTVEC, 32'h0000_1001);
    mem_msip = 1'b1;
    mem_mtime = 64'd100;
    mem_mtimecmp = 64'd50;
    expect_read(`CSR_ADDR_MIP, MIE_MASK, "mip");
    enter_user(32'h0000_0080);
    ecall = 1'b1;
    expect_cycle(1'b1, 32'h0000_102c);
    ecall = 1'b0;
    expect_read(`CSR_ADDR_MCAUSE, INT_BIT | `CSR_BIT_MEI, "mcause");
    external_interrupt = 1'b0;
    enter_user(32'h0000_0080);
    expect_cycle(1'b1, 32'h0000_101c);
    expect_read(`CSR_ADDR_MCAUSE, INT_BIT | `CSR_BIT_MTI, "mcause");
    mem_mtime = 64'd99;
    mem_mtimecmp = 64'd100;
    expect_read(`CSR_ADDR_MIP, 32'h0000_0008, "mip");
    mem_mtime = 64'd100;
    expect_read(`CSR_ADDR_MIP, 32'h0000_0088, "mip");
    mem_mtimecmp = '1;
    // U mode takes the interrupt even with MIE clear
    enter_user(32'h0000_0000);
    expect_cycle(1'b1, 32'h0000_100c);
    expect_read(`CSR_ADDR_MCAUSE, INT_BIT | `CSR_BIT_MSI, "mcause");
    mem_msip = 1'b0;
    finish_test("interrupts");
  endtask

  task automatic trap_blocking_test();
    csr_write(`CSR_ADDR_MSCRATCH, 32'h1111_1111);
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0008);
    ecall = 1'b1;
    wr_en = 1'b1;
    addr = `CSR_ADDR_MSCRATCH;
    wr_data = 32'h2222_2222;
    expect_cycle(1'b1, 32'h0000_1000);
    set_idle();
    expect_read(`CSR_ADDR_MSCRATCH, 32'h1111_1111, "mscratch");
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0008);
    ecall = 1'b1;
    wr_en = 1'b1;
    addr = `CSR_ADDR_MTVEC;
    wr_data = 32'h0000_3000;
    expect_cycle(1'b1, 32'h0000_1000);
    set_idle();
    expect_read(`CSR_ADDR_MTVEC, 32'h0000_1001, "mtvec");
    csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0088);
    ecall = 1'b1;
    mret = 1'b1;
    expect_cycle(1'b1, 32'h0000_1000);
    set_idle();
    if (privilege_mode !== PRIV_M) report_mismatch("privilege_mode", 3, xlen_t'(privilege_mode));
    expect_read(`CSR_ADDR_MSTATUS, 32'h0000_1880, "mstatus");
    expect_read(`CSR_ADDR_MCAUSE, `CSR_CAUSE_ECALL_M, "mcause");
    finish_test("trap_blocking");
  endtask

  task automatic random_test();
    int         choice;
    logic [3:0] pick;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      choice = $urandom_range(9, 0);
      pick = 4'($urandom_range(9, 0));
      wr_en = (choice < 4);
      mret = (choice == 4);
      ecall = (choice == 5) || (choice == 9);
      illegal_instruction = (choice == 6);
      addr = CSR_ADDRS[pick];
      wr_data = $urandom();
      // Small codes so that legal and illegal mcause values both occur
      if (addr == `CSR_ADDR_MCAUSE && choice < 2) begin
        wr_data = ($urandom() & INT_BIT) | $urandom_range(11, 2);
      end
      pc = $urandom();
      instruction = $urandom();
      if ($urandom_range(15, 0) == 0) external_interrupt = ~external_interrupt;
      if ($urandom_range(15, 0) == 0) mem_msip = ~mem_msip;
      if ($urandom_range(15, 0) == 0) begin
        mem_mtime = {32'd0, $urandom_range(255, 0)};
        mem_mtimecmp = {32'd0, $urandom_range(255, 0)};
      end
      next_cycle();
    end
    set_idle();
    next_cycle();
    finish_test("random");
  endtask

  initial begin
    void'($urandom(85));
    error_count = 0;
    check_count = 0;
    test_count = 0;
    errors_before = 0;
    reset = 1'b1;
    set_idle();
    addr = '0;
    wr_data = '0;
    pc = '0;
    instruction = '0;
    external_interrupt = 1'b0;
    mem_msip = 1'b0;
    mem_mtime = '0;
    mem_mtimecmp = '1;
    m_priv = PRIV_M;
    m_mpp = PRIV_U;
    m_mie = 1'b0;
    m_mpie = 1'b0;
    m_mtvec = '0;
    m_mie_reg = '0;
    m_mscratch = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    repeat (10) @(posedge clock);
    #2;
    reset = 1'b0;
    reset_test();
    write_test();
    exception_test();
    interrupt_test();
    trap_blocking_test();
    random_test();
    $display("Summary: %0d tests, %0d cycle comparisons, %0d errors",
             test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
logic/csr_pkg.sv
logic/status_priv.sv
logic/machine_setup_regs.sv
logic/trap_control.sv
logic/trap_state_regs.sv
logic/csr_file.sv
bench/csr_file_tb.sv

// File: run.sh
#!/bin/sh
# Build the CSR file testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module csr_file_tb -o csr_file_sim || exit 1
output=$(./obj_dir/csr_file_sim)
echo "$output"
echo "$output" | grep -qx "TESTBENCH PASSED" && echo "Run passed" || { echo "Run failed"; exit 1; }
